//--- tilemap_consts.svh
`ifndef TILEMAP_CONSTS_SVH
`define TILEMAP_CONSTS_SVH

// visible pixels per line
`define LINE_W 256

// pixel FIFO depth per layer, also the credits at line start
`define PIX_FIFO_DEPTH 4
`define CREDIT_W 3

// memory address widths
`define ROM_AW 15
`define SCAN_AW 10

// position and colour widths
`define XPOS_W 9
`define YPOS_W 8
`define PAL_W 4
`define COLOR_W 4
`define CODE_W 10

`endif

//--- tilemap_pkg.sv
`include "tilemap_consts.svh"

package tilemap_pkg;

    typedef logic [`XPOS_W-1:0]  xpos_t;       // screen x, 0 to LINE_W-1 plus end marker
    typedef logic [`YPOS_W-1:0]  ypos_t;       // map y, wraps at 256
    typedef logic [`PAL_W-1:0]   pal_t;        // attribute bits 3..0
    typedef logic [`COLOR_W-1:0] color_t;      // 0 is transparent
    typedef logic [`CODE_W-1:0]  tile_code_t;  // attr[7:6] above code byte

    // layer, tile code, tile row, half-row
    typedef logic [`ROM_AW-1:0]  rom_addr_t;

    // map row above map column
    typedef logic [`SCAN_AW-1:0] scan_addr_t;

    // fetcher to mixer
    typedef struct packed {
        xpos_t  x;
        pal_t   pal;
        color_t color;
    } pixel_t;

    // line buffer entry
    typedef struct packed {
        pal_t   pal;
        color_t color;
    } mix_pix_t;

    typedef enum logic [2:0] {
        IDLE,
        SCAN,
        SCAN_WAIT,
        ROM_REQ,
        ROM_WAIT,
        DUMP,
        NEXT
    } fetch_st_e;

endpackage

//--- pixel_fifo.sv
`timescale 1ns/1ps
`include "tilemap_consts.svh"

module pixel_fifo (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                push,
    input  tilemap_pkg::pixel_t push_pix,
    input  logic                pop,
    output logic                empty,
    output tilemap_pkg::pixel_t head,
    output logic                credit
);

    localparam int DEPTH = `PIX_FIFO_DEPTH;
    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] CNT_ONE = 1;

    tilemap_pkg::pixel_t mem [DEPTH];
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic [AW:0]         count;
    logic                full;

    assign empty = (count == '0);
    assign full  = (count == DEPTH[AW:0]);
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wr_ptr] <= push_pix;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count  <= count + (push ? CNT_ONE : '0) - (pop ? CNT_ONE : '0);
            credit <= pop;  // one credit back per slot freed
        end
    end

    // the fetcher's credit count keeps it from overrunning
    no_push_full: assert property (
        @(posedge clk) disable iff (rst || flush)
        push |-> !full
    );

endmodule

//--- line_buffer.sv
`timescale 1ns/1ps
`include "tilemap_consts.svh"

module line_buffer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  swap,
    input  logic                  we,
    input  tilemap_pkg::xpos_t    wr_x,
    input  tilemap_pkg::mix_pix_t wr_pix,
    input  tilemap_pkg::xpos_t    rd_x,
    output tilemap_pkg::mix_pix_t rd_pix,
    output logic                  wr_bank
);

    localparam int XW = $clog2(`LINE_W);

    // bank bit above pixel index
    tilemap_pkg::mix_pix_t mem [2*`LINE_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_bank <= 1'b0;
        end else if (swap) begin
            wr_bank <= ~wr_bank;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[{wr_bank, wr_x[XW-1:0]}] <= wr_pix;
        end
        rd_pix <= mem[{~wr_bank, rd_x[XW-1:0]}];  // display side, previous line
    end

    // a bank swap lands on a line start, when the mixer is idle
    no_write_on_swap: assert property (
        @(posedge clk) disable iff (rst)
        swap |-> !we
    );

endmodule

//--- line_mixer.sv
`timescale 1ns/1ps
`include "tilemap_consts.svh"

module line_mixer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  line_start,
    input  logic                  scroll_valid,
    input  tilemap_pkg::pixel_t   scroll_pix,
    input  logic                  char_valid,
    input  tilemap_pkg::pixel_t   char_pix,
    output logic                  scroll_credit,
    output logic                  char_credit,
    output logic                  we,
    output tilemap_pkg::xpos_t    wr_x,
    output tilemap_pkg::mix_pix_t wr_pix,
    output logic                  line_done
);

    localparam tilemap_pkg::xpos_t LAST_X = tilemap_pkg::xpos_t'(`LINE_W - 1);

    logic                scr_empty;
    logic                chr_empty;
    tilemap_pkg::pixel_t scr_head;
    tilemap_pkg::pixel_t chr_head;
    logic                pop;

    // both layers advance together, the slower one sets the pace
    assign pop = !scr_empty && !chr_empty && !line_start;

    pixel_fifo u_scr_fifo (
        .clk      (clk),
        .rst      (rst),
        .flush    (line_start),
        .push     (scroll_valid),
        .push_pix (scroll_pix),
        .pop      (pop),
        .empty    (scr_empty),
        .head     (scr_head),
        .credit   (scroll_credit)
    );

    pixel_fifo u_chr_fifo (
        .clk      (clk),
        .rst      (rst),
        .flush    (line_start),
        .push     (char_valid),
        .push_pix (char_pix),
        .pop      (pop),
        .empty    (chr_empty),
        .head     (chr_head),
        .credit   (char_credit)
    );

    assign we   = pop;
    assign wr_x = chr_head.x;

    // char on top, colour 0 lets the scroll layer through
    always_comb begin
        if (chr_head.color != '0) begin
            wr_pix.pal   = chr_head.pal;
            wr_pix.color = chr_head.color;
        end else begin
            wr_pix.pal   = scr_head.pal;
            wr_pix.color = scr_head.color;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            line_done <= 1'b1;
        end else if (line_start) begin
            line_done <= 1'b0;
        end else if (pop && wr_x == LAST_X) begin
            line_done <= 1'b1;  // last pixel just written
        end
    end

    // both fetchers must stay in step pixel for pixel
    heads_aligned: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> scr_head.x == chr_head.x
    );

endmodule

//--- tile_layer_fetch.sv
`timescale 1ns/1ps
`include "tilemap_consts.svh"

module tile_layer_fetch #(
    parameter int LAYER_ID = 0  // 0 scroll, 1 char
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    line_start,
    input  tilemap_pkg::ypos_t      vrender,
    input  tilemap_pkg::xpos_t      scroll_x,
    input  tilemap_pkg::ypos_t      scroll_y,
    input  logic [7:0]              scan_code,
    input  logic [7:0]              scan_attr,
    input  logic                    rom_ok,
    input  logic [15:0]             rom_data,
    input  logic                    pix_credit,
    output tilemap_pkg::scan_addr_t scan_addr,
    output logic                    rom_cs,
    output tilemap_pkg::rom_addr_t  rom_addr,
    output logic                    pix_valid,
    output tilemap_pkg::pixel_t     pix
);

    localparam int CRED_INIT = `PIX_FIFO_DEPTH;
    localparam logic LAYER_BIT = LAYER_ID[0];
    localparam tilemap_pkg::xpos_t LAST_X = tilemap_pkg::xpos_t'(`LINE_W - 1);
    localparam tilemap_pkg::xpos_t END_X = tilemap_pkg::xpos_t'(`LINE_W);
    localparam logic [`CREDIT_W-1:0] CRED_ONE = 1;

    tilemap_pkg::fetch_st_e  st;
    logic [7:0]              mx;        // map x of the current 4-pixel group
    tilemap_pkg::ypos_t      my;        // map y for the whole line
    tilemap_pkg::xpos_t      sx;        // next screen x to send
    logic [1:0]              nib;       // nibble within the ROM word
    logic [15:0]             pxl_data;
    tilemap_pkg::tile_code_t code;
    tilemap_pkg::pal_t       pal;
    logic [`CREDIT_W-1:0]    credits;
    logic                    send;
    logic [7:0]              mx_start;
    tilemap_pkg::ypos_t      my_start;

    // the char layer does not scroll
    assign mx_start = (LAYER_ID == 0) ? scroll_x[7:0] : 8'd0;
    assign my_start = (LAYER_ID == 0) ? vrender + scroll_y : vrender;

    assign scan_addr = {my[7:3], mx[7:3]};
    assign rom_addr  = {LAYER_BIT, code, my[2:0], mx[2]};

    assign send = (st == tilemap_pkg::DUMP) && (credits != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            st        <= tilemap_pkg::IDLE;
            rom_cs    <= 1'b0;
            pix_valid <= 1'b0;
            credits   <= CRED_INIT[`CREDIT_W-1:0];
        end else if (line_start) begin
            // also aborts an unfinished line
            st        <= tilemap_pkg::SCAN;
            rom_cs    <= 1'b0;
            pix_valid <= 1'b0;
            credits   <= CRED_INIT[`CREDIT_W-1:0];
            mx        <= mx_start;
            my        <= my_start;
            sx        <= '0;
        end else begin
            credits   <= credits + (pix_credit ? CRED_ONE : '0) - (send ? CRED_ONE : '0);
            pix_valid <= send;
            case (st)
                tilemap_pkg::IDLE: ;  // line finished
                tilemap_pkg::SCAN: begin
                    st <= tilemap_pkg::SCAN_WAIT;  // scan_addr presented
                end
                tilemap_pkg::SCAN_WAIT: begin
                    code <= {scan_attr[7:6], scan_code};
                    pal  <= scan_attr[3:0];
                    st   <= tilemap_pkg::ROM_REQ;
                end
                tilemap_pkg::ROM_REQ: begin
                    rom_cs <= 1'b1;
                    st     <= tilemap_pkg::ROM_WAIT;
                end
                tilemap_pkg::ROM_WAIT: begin
                    if (rom_ok) begin
                        pxl_data <= rom_data;
                        rom_cs   <= 1'b0;
                        nib      <= mx[1:0];  // skips leading nibbles on a fine scroll
                        st       <= tilemap_pkg::DUMP;
                    end
                end
                tilemap_pkg::DUMP: begin
                    // stalls here while out of credits
                    if (send) begin
                        pix.x     <= sx;
                        pix.pal   <= pal;
                        pix.color <= pxl_data[{~nib, 2'b00} +: 4];  // left pixel in MSBs
                        sx        <= sx + 1'b1;
                        nib       <= nib + 1'b1;
                        if (nib == 2'd3 || sx == LAST_X) begin
                            st <= tilemap_pkg::NEXT;
                        end
                    end
                end
                tilemap_pkg::NEXT: begin
                    if (sx == END_X) begin
                        st <= tilemap_pkg::IDLE;
                    end else begin
                        mx <= {mx[7:2] + 6'd1, 2'b00};
                        // second half of a tile reuses the scan entry
                        st <= mx[2] ? tilemap_pkg::SCAN : tilemap_pkg::ROM_REQ;
                    end
                end
                default: st <= tilemap_pkg::IDLE;
            endcase
        end
    end

    // ROM request must hold its address until the data comes back
    rom_addr_hold: assert property (
        @(posedge clk) disable iff (rst || line_start)
        rom_cs && !rom_ok |=> $stable(rom_addr)
    );

    // credits returned by the mixer never outnumber its FIFO slots
    credit_bound: assert property (
        @(posedge clk) disable iff (rst || line_start)
        credits <= CRED_INIT[`CREDIT_W-1:0]
    );

endmodule

//--- tilemap_gfx.sv
`timescale 1ns/1ps

module tilemap_gfx (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    lhbl,
    input  logic                    lvbl,
    input  tilemap_pkg::ypos_t      vrender,
    input  tilemap_pkg::xpos_t      scroll_x,
    input  tilemap_pkg::ypos_t      scroll_y,
    // scroll layer memories
    output tilemap_pkg::scan_addr_t scr_scan_addr,
    input  logic [7:0]              scr_scan_code,
    input  logic [7:0]              scr_scan_attr,
    output logic                    scr_rom_cs,
    output tilemap_pkg::rom_addr_t  scr_rom_addr,
    input  logic                    scr_rom_ok,
    input  logic [15:0]             scr_rom_data,
    // char layer memories
    output tilemap_pkg::scan_addr_t chr_scan_addr,
    input  logic [7:0]              chr_scan_code,
    input  logic [7:0]              chr_scan_attr,
    output logic                    chr_rom_cs,
    output tilemap_pkg::rom_addr_t  chr_rom_addr,
    input  logic                    chr_rom_ok,
    input  logic [15:0]             chr_rom_data,
    // display side
    input  tilemap_pkg::xpos_t      rd_x,
    output tilemap_pkg::mix_pix_t   rd_pix,
    output logic                    line_done
);

    logic                  last_lhbl;
    logic                  line_start;
    logic                  scr_valid;
    tilemap_pkg::pixel_t   scr_pix;
    logic                  scr_credit;
    logic                  chr_valid;
    tilemap_pkg::pixel_t   chr_pix;
    logic                  chr_credit;
    logic                  mix_we;
    tilemap_pkg::xpos_t    mix_x;
    tilemap_pkg::mix_pix_t mix_pix;

    // rising lhbl inside the active frame starts a line
    always_ff @(posedge clk) begin
        last_lhbl <= lhbl;  // previous lhbl for the edge detect
        if (rst) begin
            line_start <= 1'b0;
        end else begin
            line_start <= lhbl && !last_lhbl && lvbl;
        end
    end

    tile_layer_fetch #(.LAYER_ID(0)) u_scr_fetch (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .vrender    (vrender),
        .scroll_x   (scroll_x),
        .scroll_y   (scroll_y),
        .scan_code  (scr_scan_code),
        .scan_attr  (scr_scan_attr),
        .rom_ok     (scr_rom_ok),
        .rom_data   (scr_rom_data),
        .pix_credit (scr_credit),
        .scan_addr  (scr_scan_addr),
        .rom_cs     (scr_rom_cs),
        .rom_addr   (scr_rom_addr),
        .pix_valid  (scr_valid),
        .pix        (scr_pix)
    );

    // char layer ignores the scroll inputs
    tile_layer_fetch #(.LAYER_ID(1)) u_chr_fetch (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .vrender    (vrender),
        .scroll_x   (scroll_x),
        .scroll_y   (scroll_y),
        .scan_code  (chr_scan_code),
        .scan_attr  (chr_scan_attr),
        .rom_ok     (chr_rom_ok),
        .rom_data   (chr_rom_data),
        .pix_credit (chr_credit),
        .scan_addr  (chr_scan_addr),
        .rom_cs     (chr_rom_cs),
        .rom_addr   (chr_rom_addr),
        .pix_valid  (chr_valid),
        .pix        (chr_pix)
    );

    line_mixer u_mixer (
        .clk           (clk),
        .rst           (rst),
        .line_start    (line_start),
        .scroll_valid  (scr_valid),
        .scroll_pix    (scr_pix),
        .char_valid    (chr_valid),
        .char_pix      (chr_pix),
        .scroll_credit (scr_credit),
        .char_credit   (chr_credit),
        .we            (mix_we),
        .wr_x          (mix_x),
        .wr_pix        (mix_pix),
        .line_done     (line_done)
    );

    line_buffer u_line_buffer (
        .clk     (clk),
        .rst     (rst),
        .swap    (line_start),
        .we      (mix_we),
        .wr_x    (mix_x),
        .wr_pix  (mix_pix),
        .rd_x    (rd_x),
        .rd_pix  (rd_pix),
        .wr_bank ()
    );

endmodule

//--- tb_tile_models.sv
`timescale 1ns/1ps
`include "tilemap_consts.svh"

// graphics ROM behind a request/ok handshake, latency set per request
module gfx_rom_model (
    input  logic                   clk,
    input  logic                   cs,
    input  tilemap_pkg::rom_addr_t addr,
    input  logic [3:0]             lat,
    output logic                   ok,
    output logic [15:0]            data
);

    logic       busy;
    logic [3:0] wait_cnt;

    // address times an odd constant, every fourth word gets a clear right pixel
    function automatic logic [15:0] word_at(input tilemap_pkg::rom_addr_t a);
        logic [15:0] w;
        w = 16'(32'(a) * 32'h9e37);
        if (a[1:0] == 2'b00) begin
            w[3:0] = 4'h0;
        end
        return w;
    endfunction

    initial begin
        ok       = 1'b0;
        data     = '0;
        busy     = 1'b0;
        wait_cnt = '0;
    end

    always @(posedge clk) begin
        ok <= 1'b0;
        if (!cs) begin
            busy <= 1'b0;  // request withdrawn
        end else if (busy) begin
            if (wait_cnt == 4'd1) begin
                ok   <= 1'b1;
                data <= word_at(addr);
                busy <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 4'd1;
            end
        end else if (!ok) begin
            if (lat <= 4'd1) begin
                ok   <= 1'b1;
                data <= word_at(addr);
            end else begin
                busy     <= 1'b1;
                wait_cnt <= lat - 4'd1;
            end
        end
    end

endmodule

module tb_tile_models (
    input  logic                    clk,
    input  tilemap_pkg::scan_addr_t scr_scan_addr,
    output logic [7:0]              scr_scan_code,
    output logic [7:0]              scr_scan_attr,
    input  logic                    scr_rom_cs,
    input  tilemap_pkg::rom_addr_t  scr_rom_addr,
    output logic                    scr_rom_ok,
    output logic [15:0]             scr_rom_data,
    input  logic [3:0]              scr_lat,
    input  tilemap_pkg::scan_addr_t chr_scan_addr,
    output logic [7:0]              chr_scan_code,
    output logic [7:0]              chr_scan_attr,
    input  logic                    chr_rom_cs,
    input  tilemap_pkg::rom_addr_t  chr_rom_addr,
    output logic                    chr_rom_ok,
    output logic [15:0]             chr_rom_data,
    input  logic [3:0]              chr_lat
);

    // loaded by the testbench before reset ends
    logic [7:0] scr_code_mem [1 << `SCAN_AW];
    logic [7:0] scr_attr_mem [1 << `SCAN_AW];
    logic [7:0] chr_code_mem [1 << `SCAN_AW];
    logic [7:0] chr_attr_mem [1 << `SCAN_AW];

    initial begin
        scr_scan_code = '0;
        scr_scan_attr = '0;
        chr_scan_code = '0;
        chr_scan_attr = '0;
    end

    // scan RAMs answer one cycle after the address
    always @(posedge clk) begin
        scr_scan_code <= scr_code_mem[scr_scan_addr];
        scr_scan_attr <= scr_attr_mem[scr_scan_addr];
        chr_scan_code <= chr_code_mem[chr_scan_addr];
        chr_scan_attr <= chr_attr_mem[chr_scan_addr];
    end

    gfx_rom_model u_scr_rom (
        .clk  (clk),
        .cs   (scr_rom_cs),
        .addr (scr_rom_addr),
        .lat  (scr_lat),
        .ok   (scr_rom_ok),
        .data (scr_rom_data)
    );

    gfx_rom_model u_chr_rom (
        .clk  (clk),
        .cs   (chr_rom_cs),
        .addr (chr_rom_addr),
        .lat  (chr_lat),
        .ok   (chr_rom_ok),
        .data (chr_rom_data)
    );

endmodule

//--- tb_tilemap.sv
`timescale 1ns/1ps
`include "tilemap_consts.svh"

module tb_tilemap;

    localparam int MAP_N         = 1 << `SCAN_AW;
    localparam int START_TIMEOUT = 16;
    localparam int DONE_TIMEOUT  = 20000;

    logic                    clk;
    logic                    rst;
    logic                    lhbl;
    logic                    lvbl;
    tilemap_pkg::ypos_t      vrender;
    tilemap_pkg::xpos_t      scroll_x;
    tilemap_pkg::ypos_t      scroll_y;
    tilemap_pkg::xpos_t      rd_x;
    tilemap_pkg::mix_pix_t   rd_pix;
    logic                    line_done;
    tilemap_pkg::scan_addr_t scr_scan_addr;
    logic [7:0]              scr_scan_code;
    logic [7:0]              scr_scan_attr;
    logic                    scr_rom_cs;
    tilemap_pkg::rom_addr_t  scr_rom_addr;
    logic                    scr_rom_ok;
    logic [15:0]             scr_rom_data;
    tilemap_pkg::scan_addr_t chr_scan_addr;
    logic [7:0]              chr_scan_code;
    logic [7:0]              chr_scan_attr;
    logic                    chr_rom_cs;
    tilemap_pkg::rom_addr_t  chr_rom_addr;
    logic                    chr_rom_ok;
    logic [15:0]             chr_rom_data;
    logic [3:0]              scr_lat = 4'd1;
    logic [3:0]              chr_lat = 4'd1;
    logic                    rand_lat;
    logic [31:0]             lfsr;

    // mirrors of the scan RAMs
    logic [7:0] scr_code [MAP_N];
    logic [7:0] scr_attr [MAP_N];
    logic [7:0] chr_code [MAP_N];
    logic [7:0] chr_attr [MAP_N];

    tilemap_pkg::mix_pix_t exp_new [`LINE_W];
    tilemap_pkg::mix_pix_t exp_prev [`LINE_W];
    logic                  have_prev;
    int                    line_count;
    int                    n_clear;  // char pixels with colour 0
    int                    n_solid;

    tilemap_gfx u_tilemap_gfx (
        .clk           (clk),
        .rst           (rst),
        .lhbl          (lhbl),
        .lvbl          (lvbl),
        .vrender       (vrender),
        .scroll_x      (scroll_x),
        .scroll_y      (scroll_y),
        .scr_scan_addr (scr_scan_addr),
        .scr_scan_code (scr_scan_code),
        .scr_scan_attr (scr_scan_attr),
        .scr_rom_cs    (scr_rom_cs),
        .scr_rom_addr  (scr_rom_addr),
        .scr_rom_ok    (scr_rom_ok),
        .scr_rom_data  (scr_rom_data),
        .chr_scan_addr (chr_scan_addr),
        .chr_scan_code (chr_scan_code),
        .chr_scan_attr (chr_scan_attr),
        .chr_rom_cs    (chr_rom_cs),
        .chr_rom_addr  (chr_rom_addr),
        .chr_rom_ok    (chr_rom_ok),
        .chr_rom_data  (chr_rom_data),
        .rd_x          (rd_x),
        .rd_pix        (rd_pix),
        .line_done     (line_done)
    );

    tb_tile_models u_models (
        .clk           (clk),
        .scr_scan_addr (scr_scan_addr),
        .scr_scan_code (scr_scan_code),
        .scr_scan_attr (scr_scan_attr),
        .scr_rom_cs    (scr_rom_cs),
        .scr_rom_addr  (scr_rom_addr),
        .scr_rom_ok    (scr_rom_ok),
        .scr_rom_data  (scr_rom_data),
        .scr_lat       (scr_lat),
        .chr_scan_addr (chr_scan_addr),
        .chr_scan_code (chr_scan_code),
        .chr_scan_attr (chr_scan_attr),
        .chr_rom_cs    (chr_rom_cs),
        .chr_rom_addr  (chr_rom_addr),
        .chr_rom_ok    (chr_rom_ok),
        .chr_rom_data  (chr_rom_data),
        .chr_lat       (chr_lat)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic lfsr_step();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[6:0], lfsr_step()};
        end
        return r;
    endfunction

    // new latency for each port every cycle, 1 to 8
    always @(posedge clk) begin
        if (rand_lat) begin
            scr_lat <= 4'd1 + 4'(rand_bits(3));
            chr_lat <= 4'd1 + 4'(rand_bits(3));
        end
    end

    function automatic logic [15:0] rom_word(input int a);
        logic [15:0] w;
        w = 16'(a * 32'h9e37);
        if (a % 4 == 0) begin
            w[3:0] = 4'h0;
        end
        return w;
    endfunction

    function automatic tilemap_pkg::mix_pix_t layer_pixel(input int layer, input int mx,
                                                         input int my);
        int                    entry;
        int                    addr;
        logic [7:0]            code;
        logic [7:0]            attr;
        logic [15:0]           w;
        tilemap_pkg::mix_pix_t p;
        entry = (my / 8) * 32 + mx / 8;
        code  = (layer == 0) ? scr_code[entry] : chr_code[entry];
        attr  = (layer == 0) ? scr_attr[entry] : chr_attr[entry];
        // layer, 10-bit code, row, half-row
        addr  = layer * 16384 + (int'(attr[7:6]) * 256 + int'(code)) * 16
                + (my % 8) * 2 + (mx % 8) / 4;
        w     = rom_word(addr);
        p.pal   = attr[3:0];
        p.color = w[(3 - mx % 4) * 4 +: 4];  // left pixel in the top nibble
        return p;
    endfunction

    task automatic expected_line(input int v, input int sx, input int sy);
        tilemap_pkg::mix_pix_t s;
        tilemap_pkg::mix_pix_t c;
        n_clear = 0;
        n_solid = 0;
        for (int x = 0; x < `LINE_W; x++) begin
            s = layer_pixel(0, (x + sx) % 256, (v + sy) % 256);
            c = layer_pixel(1, x, v);
            if (c.color == 4'h0) begin
                exp_new[x] = s;
                n_clear++;
            end else begin
                exp_new[x] = c;
                n_solid++;
            end
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t: %s got 0x%0h expected 0x%0h", $time, what, got,
                     expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("Simulation failed");
        $fatal(1, "wait timed out");
    endtask

    task automatic wait_line_done(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (line_done !== level) begin
            if (n == limit) begin
                timeout_abort(what);
            end
            @(posedge clk);
            n++;
        end
    endtask

    task automatic fill_scan_rams();
        for (int i = 0; i < MAP_N; i++) begin
            scr_code[i] = rand_bits(8);
            scr_attr[i] = rand_bits(8);
            chr_code[i] = rand_bits(8);
            chr_attr[i] = rand_bits(8);
            u_models.scr_code_mem[i] = scr_code[i];
            u_models.scr_attr_mem[i] = scr_attr[i];
            u_models.chr_code_mem[i] = chr_code[i];
            u_models.chr_attr_mem[i] = chr_attr[i];
        end
    endtask

    task automatic start_line(input tilemap_pkg::ypos_t v, input tilemap_pkg::xpos_t sx,
                              input tilemap_pkg::ypos_t sy);
        @(posedge clk);
        vrender  <= v;
        scroll_x <= sx;
        scroll_y <= sy;
        lvbl     <= 1'b1;
        lhbl     <= 1'b1;
        @(posedge clk);
        lhbl <= 1'b0;
        wait_line_done(1'b0, START_TIMEOUT, "line_done did not fall after a line start");
    endtask

    // display side, runs while the next line is being drawn
    task automatic read_prev_line();
        for (int i = 0; i < `LINE_W + 2; i++) begin
            @(posedge clk);
            if (i >= 2) begin
                check_value($sformatf("line %0d pixel %0d", line_count - 1, i - 2), rd_pix,
                            exp_prev[i - 2]);
            end
            if (i < `LINE_W) begin
                rd_x <= tilemap_pkg::xpos_t'(i);
            end
        end
    endtask

    // draws one line and checks the one before it from the other bank
    task automatic render_line(input tilemap_pkg::ypos_t v, input tilemap_pkg::xpos_t sx,
                               input tilemap_pkg::ypos_t sy);
        expected_line(int'(v), int'(sx), int'(sy));
        start_line(v, sx, sy);
        if (have_prev) begin
            read_prev_line();
        end
        wait_line_done(1'b1, DONE_TIMEOUT, "line_done did not rise after rendering");
        exp_prev   = exp_new;
        have_prev  = 1'b1;
        line_count++;
    endtask

    task automatic test_reset_state();
        check_value("scroll rom_cs after reset", scr_rom_cs, 0);
        check_value("char rom_cs after reset", chr_rom_cs, 0);
        check_value("line_done after reset", line_done, 1);
        @(posedge clk);
        lvbl <= 1'b0;
        lhbl <= 1'b1;
        @(posedge clk);
        lhbl <= 1'b0;
        repeat (8) begin
            @(posedge clk);
            check_value("line_done in vblank", line_done, 1);
            check_value("rom_cs in vblank", {scr_rom_cs, chr_rom_cs}, 0);
        end
    endtask

    task automatic test_zero_scroll();
        render_line(8'h21, 9'h000, 8'h00);
    endtask

    task automatic test_fine_scroll_wrap();
        render_line(8'h40, 9'h05b, 8'hf3);  // y wraps past 255, x across the map edge
    endtask

    task automatic test_char_priority();
        // even row, so char half-row words with a clear right pixel are fetched
        render_line(8'h36, 9'h02c, 8'h10);
        check_value("char pixels with colour 0 present", n_clear != 0, 1);
        check_value("char pixels with colour present", n_solid != 0, 1);
    endtask

    task automatic test_random_latency();
        @(posedge clk);
        rand_lat <= 1'b1;
        render_line(8'h00, 9'h0ff, 8'h80);
        render_line(8'h01, 9'h003, 8'hff);
        render_line(8'hff, 9'h1fe, 8'h01);
        render_line(8'h9a, 9'h077, 8'h66);
        // one more swap brings the last line to the display side
        render_line(8'h10, 9'h000, 8'h00);
    endtask

    initial begin
        rst        = 1'b1;
        lhbl       = 1'b0;
        lvbl       = 1'b0;
        vrender    = '0;
        scroll_x   = '0;
        scroll_y   = '0;
        rd_x       = '0;
        rand_lat   = 1'b0;
        have_prev  = 1'b0;
        line_count = 0;
        lfsr       = 32'h63e6_e3c4;
        fill_scan_rams();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_reset_state();
        test_zero_scroll();
        test_fine_scroll_wrap();
        test_char_priority();
        test_random_latency();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- project.f
+incdir+.
tilemap_pkg.sv
pixel_fifo.sv
line_buffer.sv
line_mixer.sv
tile_layer_fetch.sv
tilemap_gfx.sv
tb_tile_models.sv
tb_tilemap.sv
